//--- verilog/pollable_memory_pkg.sv
//--------------------------------------------------------------------
// pollable memory package
// sizes of the word memory, SPI frame layout and command codes,
// credit depth of the playback byte stream and the byte lane rule
//--------------------------------------------------------------------
package pollable_memory_pkg;

	// memory format
	localparam int mem_words = 512;
	localparam int word_bits = 32;
	localparam int word_addr_bits = 9;
	localparam int byte_addr_bits = 11;

	// spi frame is command byte, 16-bit address, 32-bit data word
	localparam int frame_bits = 56;
	localparam int header_bits = 24;
	localparam int bit_count_bits = 6;
	localparam logic [7:0] cmd_write = 8'h01;
	localparam logic [7:0] cmd_read = 8'h02;

	// credits held by the sequencer, same as serializer queue depth
	localparam int credit_depth = 4;
	localparam int credit_bits = 3;
	localparam int queue_ptr_bits = 2;

	// byte b lives in word b/4, lane 0 is the most significant byte
	function automatic logic [7:0] byte_lane_of(
		input logic [word_bits-1:0] word,
		input logic [1:0] lane
	);
		return word[8*(3-lane) +: 8];
	endfunction

endpackage

//--- verilog/mem_word_port_if.sv
//--------------------------------------------------------------------
// word port of the pollable RAM
// 32-bit synchronous read/write port, one cycle of read latency
//--------------------------------------------------------------------
`timescale 1ns/1ps

interface mem_word_port_if
	import pollable_memory_pkg::*;
();

	// write strobe, any clock edge with we high stores wdata
	logic we;
	logic [word_addr_bits-1:0] addr;
	logic [word_bits-1:0] wdata;
	// word at addr, one cycle after addr is presented
	logic [word_bits-1:0] rdata;

	modport host (
		output we,
		output addr,
		output wdata,
		input rdata
	);

	modport mem (
		input we,
		input addr,
		input wdata,
		output rdata
	);

endinterface

//--- verilog/spi_command_slave.sv
//--------------------------------------------------------------------
// SPI command slave
// mode 0 slave, MSB first, 56-bit frames of command, address, data
// writes store the data word into the RAM when cs_n rises, reads
// fetch the word after the address and return it in the data phase
//--------------------------------------------------------------------
`timescale 1ns/1ps

module spi_command_slave
	import pollable_memory_pkg::*;
(
	input logic clock50,
	input logic reset3,
	input logic sclk,
	input logic mosi,
	input logic cs_n,
	output logic miso,
	mem_word_port_if.host mem
);

	logic [2:0] sclk_sync;
	logic [2:0] cs_sync;
	logic [1:0] mosi_sync;
	logic sclk_rise;
	logic sclk_fall;
	logic cs_rise;
	logic cs_fall;
	logic cs_active;
	logic [bit_count_bits-1:0] bit_count;
	logic [frame_bits-1:0] rx_shift;
	logic [frame_bits-1:0] rx_next;
	logic [word_bits-1:0] tx_shift;
	logic header_done;
	logic read_start;
	logic frame_write;
	logic [1:0] read_pending;

	// three flops on sclk and cs_n, mosi aligned to the edge stage
	always_ff @(posedge clock50) begin
		if (reset3) begin
			sclk_sync <= '0;
			cs_sync <= '1;
			mosi_sync <= '0;
		end else begin
			sclk_sync <= {sclk_sync[1:0], sclk};
			cs_sync <= {cs_sync[1:0], cs_n};
			mosi_sync <= {mosi_sync[0], mosi};
		end
	end

	assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
	assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
	assign cs_rise = cs_sync[1] & ~cs_sync[2];
	assign cs_fall = ~cs_sync[1] & cs_sync[2];
	assign cs_active = ~cs_sync[1];

	assign rx_next = {rx_shift[frame_bits-2:0], mosi_sync[1]};

	// command and address complete on the 24th sampled bit
	assign header_done = sclk_rise && cs_active && (bit_count == header_bits - 1);
	assign read_start = header_done && (rx_next[header_bits-1 -: 8] == cmd_read);

	// only a full frame with the write command reaches the RAM
	assign frame_write = cs_rise && (bit_count == frame_bits)
		&& (rx_shift[frame_bits-1 -: 8] == cmd_write);

	always_ff @(posedge clock50) begin
		if (reset3) begin
			bit_count <= '0;
			read_pending <= '0;
			mem.we <= 1'b0;
			miso <= 1'b0;
		end else begin
			mem.we <= frame_write;
			// address out, then RAM latency, then load
			read_pending <= {read_pending[0], read_start};
			if (cs_fall) begin
				bit_count <= '0;
			end else if (sclk_rise && cs_active && bit_count != '1) begin
				bit_count <= bit_count + 1'b1;
			end
			if (!cs_active) begin
				miso <= 1'b0;
			end else if (sclk_fall) begin
				miso <= tx_shift[word_bits-1];
			end
		end
	end

	always_ff @(posedge clock50) begin
		if (sclk_rise && cs_active) begin
			rx_shift <= rx_next;
		end
		// presented for reads and held for the write at frame end
		if (header_done) begin
			mem.addr <= rx_next[word_addr_bits-1:0];
		end
		if (frame_write) begin
			mem.wdata <= rx_shift[word_bits-1:0];
		end
		if (cs_fall) begin
			tx_shift <= '0;
		end else if (read_pending[1]) begin
			tx_shift <= mem.rdata;
		end else if (sclk_fall && cs_active) begin
			tx_shift <= {tx_shift[word_bits-2:0], 1'b0};
		end
	end

endmodule

//--- verilog/pollable_ram.sv
//--------------------------------------------------------------------
// pollable RAM
// 512 x 32 storage with a read/write word port for the SPI slave
// and a read-only byte port for playback, one cycle on both
//--------------------------------------------------------------------
`timescale 1ns/1ps

module pollable_ram
	import pollable_memory_pkg::*;
(
	input logic clock50,
	mem_word_port_if.mem word_port,
	input logic [byte_addr_bits-1:0] byte_addr,
	output logic [7:0] byte_rdata
);

	// starts out all zero
	logic [word_bits-1:0] storage [mem_words] = '{default: '0};

	// word port, read returns the old word on a same-cycle write
	always_ff @(posedge clock50) begin
		if (word_port.we) begin
			storage[word_port.addr] <= word_port.wdata;
		end
		word_port.rdata <= storage[word_port.addr];
	end

	// byte port picks one lane of the word at byte_addr / 4
	always_ff @(posedge clock50) begin
		byte_rdata <= byte_lane_of(
			storage[byte_addr[byte_addr_bits-1:2]],
			byte_addr[1:0]
		);
	end

endmodule

//--- verilog/playback_sequencer.sv
//--------------------------------------------------------------------
// playback sequencer
// walks the RAM byte by byte and passes each byte to the serializer,
// one read per cycle while enabled and holding a credit
//--------------------------------------------------------------------
`timescale 1ns/1ps

module playback_sequencer
	import pollable_memory_pkg::*;
(
	input logic clock50,
	input logic reset3,
	input logic play_enable,
	output logic [byte_addr_bits-1:0] byte_addr,
	input logic [7:0] byte_rdata,
	output logic byte_valid,
	output logic [7:0] byte_data,
	input logic credit_return
);

	logic [credit_bits-1:0] credit_count;
	logic issue;

	// one credit per byte read
	assign issue = play_enable && (credit_count != '0);

	always_ff @(posedge clock50) begin
		if (reset3) begin
			byte_addr <= '0;
			byte_valid <= 1'b0;
			credit_count <= credit_bits'(credit_depth);
		end else begin
			// RAM answers one cycle after the address
			byte_valid <= issue;
			if (issue) begin
				// wraps from 2047 to 0
				byte_addr <= byte_addr + 1'b1;
			end
			unique case ({credit_return, issue})
				2'b10: credit_count <= credit_count + 1'b1;
				2'b01: credit_count <= credit_count - 1'b1;
				default: credit_count <= credit_count;
			endcase
		end
	end

	// registered lane from the RAM byte port
	assign byte_data = byte_rdata;

endmodule

//--- verilog/byte_serializer.sv
//--------------------------------------------------------------------
// byte serializer
// queues incoming bytes and shifts each out MSB first in 8 cycles,
// frame strobe on the first bit, LEDs show the byte being sent
//--------------------------------------------------------------------
`timescale 1ns/1ps

module byte_serializer
	import pollable_memory_pkg::*;
(
	input logic clock50,
	input logic reset3,
	input logic byte_valid,
	input logic [7:0] byte_data,
	output logic credit_return,
	output logic serial_out,
	output logic serial_frame,
	output logic [7:0] leds
);

	logic [7:0] queue [credit_depth];
	logic [queue_ptr_bits-1:0] wr_ptr;
	logic [queue_ptr_bits-1:0] rd_ptr;
	logic [credit_bits-1:0] queue_count;
	logic [7:0] shift_reg;
	logic [2:0] bit_index;
	logic busy;
	logic load;

	// next byte enters right after the last bit, no gap
	assign load = (queue_count != '0) && (!busy || bit_index == 3'd7);
	assign serial_out = shift_reg[7];

	always_ff @(posedge clock50) begin
		if (byte_valid) begin
			queue[wr_ptr] <= byte_data;
		end
	end

	always_ff @(posedge clock50) begin
		if (reset3) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			queue_count <= '0;
			shift_reg <= '0;
			bit_index <= '0;
			busy <= 1'b0;
			credit_return <= 1'b0;
			serial_frame <= 1'b0;
			leds <= '0;
		end else begin
			// pop frees a queue slot, hand the credit back
			credit_return <= load;
			serial_frame <= load;
			if (byte_valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			unique case ({byte_valid, load})
				2'b10: queue_count <= queue_count + 1'b1;
				2'b01: queue_count <= queue_count - 1'b1;
				default: queue_count <= queue_count;
			endcase
			if (load) begin
				rd_ptr <= rd_ptr + 1'b1;
				shift_reg <= queue[rd_ptr];
				leds <= queue[rd_ptr];
				bit_index <= '0;
				busy <= 1'b1;
			end else if (busy) begin
				// shifts in zeros, line idles low when done
				shift_reg <= {shift_reg[6:0], 1'b0};
				bit_index <= bit_index + 1'b1;
				if (bit_index == 3'd7) begin
					busy <= 1'b0;
				end
			end
		end
	end

endmodule

//--- verilog/pollable_memory_top.sv
//--------------------------------------------------------------------
// pollable memory top level
// SPI-filled word memory with continuous byte playback on a serial
// line and eight LEDs
//--------------------------------------------------------------------
`timescale 1ns/1ps

module pollable_memory_top
	import pollable_memory_pkg::*;
(
	input logic clock50,
	input logic reset3,
	input logic spi_sclk,
	input logic spi_mosi,
	input logic spi_cs_n,
	input logic play_enable,
	output logic spi_miso,
	output logic serial_out,
	output logic serial_frame,
	output logic [7:0] leds
);

	logic [byte_addr_bits-1:0] byte_addr;
	logic [7:0] byte_rdata;
	logic byte_valid;
	logic [7:0] byte_data;
	logic credit_return;

	mem_word_port_if word_bus ();

	spi_command_slave spi_slave (
		.clock50(clock50),
		.reset3(reset3),
		.sclk(spi_sclk),
		.mosi(spi_mosi),
		.cs_n(spi_cs_n),
		.miso(spi_miso),
		.mem(word_bus.host)
	);

	pollable_ram ram (
		.clock50(clock50),
		.word_port(word_bus.mem),
		.byte_addr(byte_addr),
		.byte_rdata(byte_rdata)
	);

	playback_sequencer sequencer (
		.clock50(clock50),
		.reset3(reset3),
		.play_enable(play_enable),
		.byte_addr(byte_addr),
		.byte_rdata(byte_rdata),
		.byte_valid(byte_valid),
		.byte_data(byte_data),
		.credit_return(credit_return)
	);

	byte_serializer serializer (
		.clock50(clock50),
		.reset3(reset3),
		.byte_valid(byte_valid),
		.byte_data(byte_data),
		.credit_return(credit_return),
		.serial_out(serial_out),
		.serial_frame(serial_frame),
		.leds(leds)
	);

endmodule

//--- tests/pollable_memory_assertions.sv
//--------------------------------------------------------------------
// credit protocol checks
// bound to the playback sequencer, watches byte_valid and the credit
// counter against the bytes still waiting for their credit
//--------------------------------------------------------------------
`timescale 1ns/1ps

module pollable_memory_assertions
	import pollable_memory_pkg::*;
(
	input logic clock50,
	input logic reset3,
	input logic byte_valid,
	input logic credit_return,
	input logic [credit_bits-1:0] credit_count
);

	// bytes handed to the serializer whose credit has not come back
	logic [credit_bits:0] in_flight;

	always_ff @(posedge clock50) begin
		if (reset3) begin
			in_flight <= '0;
		end else begin
			in_flight <= in_flight + (credit_bits+1)'(byte_valid)
				- (credit_bits+1)'(credit_return);
		end
	end

	// a byte may only go out while a queue slot is still free
	valid_needs_credit: assert property (
		@(posedge clock50) disable iff (reset3)
		byte_valid |-> (in_flight < credit_depth)
	) else $error("byte_valid raised with every credit outstanding");

	credit_bounded: assert property (
		@(posedge clock50) disable iff (reset3)
		credit_count <= credit_bits'(credit_depth)
	) else $error("credit counter above the queue depth");

	valid_low_after_reset: assert property (
		@(posedge clock50) reset3 |=> !byte_valid
	) else $error("byte_valid high in the cycle after reset");

endmodule

bind playback_sequencer pollable_memory_assertions credit_checks (
	.clock50(clock50),
	.reset3(reset3),
	.byte_valid(byte_valid),
	.credit_return(credit_return),
	.credit_count(credit_count)
);

//--- tests/pollable_memory_tb.sv
//--------------------------------------------------------------------
// pollable memory testbench
// SPI master tasks fill and read the word memory against a reference
// model, then the playback stream is captured from the serial line
// and compared byte by byte with the model
//--------------------------------------------------------------------
`timescale 1ns/1ps

module pollable_memory_tb
	import pollable_memory_pkg::*;
();

	localparam int clock_period = 40;
	localparam int input_delay = 2;
	localparam int sck_half = 6;
	localparam int random_pairs = 60;
	localparam int playback_bytes = 2100;
	// writes and reads, unwritten, overwrite, malformed, full load
	localparam int total_frames = 2 * random_pairs + 4 + 3 + 5 + mem_words;
	localparam int frame_cycles = frame_bits * 2 * sck_half + 4 * sck_half;
	localparam int watchdog_cycles = total_frames * frame_cycles + 2300 * 8 + 2000;

	logic clock50;
	logic reset3;
	logic spi_sclk;
	logic spi_mosi;
	logic spi_cs_n;
	logic play_enable;
	logic spi_miso;
	logic serial_out;
	logic serial_frame;
	logic [7:0] leds;

	logic [31:0] model [mem_words];
	bit written [mem_words];
	logic [8:0] written_addrs [$];
	integer seed;

	pollable_memory_top DUT (
		.clock50(clock50),
		.reset3(reset3),
		.spi_sclk(spi_sclk),
		.spi_mosi(spi_mosi),
		.spi_cs_n(spi_cs_n),
		.play_enable(play_enable),
		.spi_miso(spi_miso),
		.serial_out(serial_out),
		.serial_frame(serial_frame),
		.leds(leds)
	);

	initial begin
		clock50 = 1'b0;
		forever #(clock_period / 2) clock50 = ~clock50;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clock50);
		$display("watchdog expired before all tests completed");
		$display("Verification failed");
		$fatal(1);
	end

	task automatic wait_cycles(input int count);
		repeat (count) @(posedge clock50);
		#input_delay;
	endtask

	task automatic check_value(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("[ERROR] %s: expected %h, actual %h", test_name, expected, actual);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	// mode 0 frame, miso sampled just before each rising sck
	task automatic spi_frame(input logic [7:0] cmd, input logic [8:0] addr,
		input logic [31:0] data, input int bit_total, output logic [31:0] miso_word);
		logic [frame_bits-1:0] frame;
		frame = {cmd, 7'b0, addr, data};
		miso_word = '0;
		spi_cs_n = 1'b0;
		for (int i = 0; i < bit_total; i++) begin
			spi_mosi = frame[frame_bits-1-i];
			wait_cycles(sck_half);
			if (i >= header_bits) begin
				miso_word = {miso_word[30:0], spi_miso};
			end
			spi_sclk = 1'b1;
			wait_cycles(sck_half);
			spi_sclk = 1'b0;
		end
		wait_cycles(sck_half);
		spi_cs_n = 1'b1;
		spi_mosi = 1'b0;
		wait_cycles(sck_half);
	endtask

	task automatic write_word(input logic [8:0] addr, input logic [31:0] data);
		logic [31:0] ignored;
		spi_frame(cmd_write, addr, data, frame_bits, ignored);
		model[addr] = data;
		written[addr] = 1'b1;
		written_addrs.push_back(addr);
	endtask

	task automatic read_word(input logic [8:0] addr, output logic [31:0] word);
		spi_frame(cmd_read, addr, 32'h0, frame_bits, word);
	endtask

	initial begin
		logic [31:0] rand_word;
		logic [31:0] got_word;
		logic [31:0] expected_word;
		logic [8:0] addr;
		logic [7:0] captured;
		logic [7:0] expected_byte;
		int lane;

		seed = 32'hd48a_8a6c;
		reset3 = 1'b1;
		spi_sclk = 1'b0;
		spi_mosi = 1'b0;
		spi_cs_n = 1'b1;
		play_enable = 1'b0;
		for (int w = 0; w < mem_words; w++) begin
			model[w] = '0;
			written[w] = 1'b0;
		end
		wait_cycles(3);
		reset3 = 1'b0;

		// outputs idle after reset
		repeat (20) begin
			@(negedge clock50);
			check_value("reset_state", 32'h0, {21'b0, serial_out, serial_frame, spi_miso, leds});
		end
		wait_cycles(1);

		for (int n = 0; n < random_pairs; n++) begin
			rand_word = $random(seed);
			addr = rand_word[8:0];
			rand_word = $random(seed);
			write_word(addr, rand_word);
			rand_word = $random(seed);
			addr = written_addrs[rand_word % written_addrs.size()];
			read_word(addr, got_word);
			check_value("write_read", model[addr], got_word);
		end

		for (int n = 0; n < 4; n++) begin
			do begin
				rand_word = $random(seed);
				addr = rand_word[8:0];
			end while (written[addr]);
			read_word(addr, got_word);
			check_value("unwritten_word", 32'h0, got_word);
		end

		// second write replaces the first
		addr = written_addrs[0];
		write_word(addr, $random(seed));
		write_word(addr, $random(seed));
		read_word(addr, got_word);
		check_value("overwrite", model[addr], got_word);

		// short frame and unknown command must not store
		addr = written_addrs[1];
		write_word(addr, $random(seed));
		spi_frame(cmd_write, addr, ~model[addr], 40, got_word);
		read_word(addr, got_word);
		check_value("short_frame", model[addr], got_word);
		spi_frame(8'h5a, addr, ~model[addr], frame_bits, got_word);
		read_word(addr, got_word);
		check_value("unknown_command", model[addr], got_word);

		for (int w = 0; w < mem_words; w++) begin
			rand_word = $random(seed);
			write_word(w[8:0], rand_word);
		end

		play_enable = 1'b1;
		do @(negedge clock50); while (!serial_frame);
		for (int k = 0; k < playback_bytes; k++) begin
			captured = '0;
			for (int b = 0; b < 8; b++) begin
				if (b > 0) begin
					@(negedge clock50);
					check_value("frame_strobe", 32'h0, serial_frame);
				end
				captured = {captured[6:0], serial_out};
			end
			// byte k is lane k%4 of word (k%2048)/4, lane 0 on top
			lane = k % 4;
			expected_word = model[(k % 2048) / 4];
			expected_byte = expected_word[31 - 8 * lane -: 8];
			check_value("playback_byte", expected_byte, captured);
			check_value("leds", expected_byte, leds);
			@(negedge clock50);
			check_value("frame_spacing", 32'h1, serial_frame);
		end

		$display("Verification passed");
		$finish;
	end

endmodule

//--- sources.f
verilog/pollable_memory_pkg.sv
verilog/mem_word_port_if.sv
verilog/spi_command_slave.sv
verilog/pollable_ram.sv
verilog/playback_sequencer.sv
verilog/byte_serializer.sv
verilog/pollable_memory_top.sv
tests/pollable_memory_assertions.sv
tests/pollable_memory_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS := --binary --timing --assert -Wno-fatal -j 0
TOP := pollable_memory_tb
FILELIST := sources.f
OBJ_DIR := obj_dir
PASS_TEXT := Verification passed

SIM := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
